// File: src.f
bridge_pkg.sv
cmd_packer.sv
credit_fifo.sv
axi_write_master.sv
cmd_to_axi_top.sv
cmd_to_axi_assert.sv
tb_axi_checker.sv
tb_cmd_to_axi.sv

// File: Makefile
TOP := tb_cmd_to_axi

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run the simulation, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "TEST OK" sim.log || (echo "simulation failed, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: tb_cmd_to_axi.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cmd_to_axi;

  localparam int NCMD = 30;  // 6 whole-word, 6 partial, 18 under back-pressure

  logic                 aclk = 1'b0;
  logic                 aresetn = 1'b0;
  logic                 cmd_valid = 1'b0;
  logic                 cmd_ready;
  bridge_pkg::wr_cmd_t  cmd = '0;
  logic                 dat_tvalid = 1'b0;
  logic                 dat_tready;
  logic [7:0]           dat_tdata = 8'd0;
  logic                 dat_tlast = 1'b0;
  logic                 awvalid;
  logic                 awready = 1'b0;
  logic [31:0]          awaddr;
  logic [7:0]           awlen;
  logic [3:0]           awid;
  logic                 wvalid;
  logic                 wready = 1'b0;
  logic [31:0]          wdata;
  logic [3:0]           wstrb;
  logic                 wlast;
  logic                 bvalid = 1'b0;
  logic                 bready;
  logic [1:0]           bresp = 2'b00;
  logic [3:0]           bid = 4'd0;
  logic                 resp_valid;
  bridge_pkg::wr_resp_t resp;

  integer               seed = 38869;
  integer               rsp_seed;
  int                   nbytes [NCMD];
  bridge_pkg::wr_cmd_t  cmds [NCMD];
  int                   i;
  int                   n;
  int                   total;
  int                   limit;
  int                   cycles = 0;
  int                   err_cnt;
  int                   resp_cnt;
  int                   bp_cnt;
  logic                 stall = 1'b0;  // Responder throttles awready and wready
  logic                 aw_take = 1'b0;
  logic                 wl_take = 1'b0;
  logic                 b_take = 1'b0;
  logic [3:0]           aw_id_s = 4'd0;
  logic                 aw_err_s = 1'b0;
  logic [3:0]           pend_id = 4'd0;
  logic                 pend_err = 1'b0;

  always #20 aclk = ~aclk;

  cmd_to_axi_top #(
    .CMD_DEPTH  (4),
    .DATA_DEPTH (16)
  ) DUT (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .cmd_valid_i  (cmd_valid),
    .cmd_ready_o  (cmd_ready),
    .cmd_i        (cmd),
    .dat_tvalid_i (dat_tvalid),
    .dat_tready_o (dat_tready),
    .dat_tdata_i  (dat_tdata),
    .dat_tlast_i  (dat_tlast),
    .awvalid_o    (awvalid),
    .awready_i    (awready),
    .awaddr_o     (awaddr),
    .awlen_o      (awlen),
    .awid_o       (awid),
    .wvalid_o     (wvalid),
    .wready_i     (wready),
    .wdata_o      (wdata),
    .wstrb_o      (wstrb),
    .wlast_o      (wlast),
    .bvalid_i     (bvalid),
    .bready_o     (bready),
    .bresp_i      (bresp),
    .bid_i        (bid),
    .resp_valid_o (resp_valid),
    .resp_o       (resp)
  );

  tb_axi_checker u_checker (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .cmd_valid_i  (cmd_valid),
    .cmd_ready_i  (cmd_ready),
    .cmd_i        (cmd),
    .dat_tvalid_i (dat_tvalid),
    .dat_tready_i (dat_tready),
    .dat_tdata_i  (dat_tdata),
    .dat_tlast_i  (dat_tlast),
    .awvalid_i    (awvalid),
    .awready_i    (awready),
    .awaddr_i     (awaddr),
    .awlen_i      (awlen),
    .awid_i       (awid),
    .wvalid_i     (wvalid),
    .wready_i     (wready),
    .wdata_i      (wdata),
    .wstrb_i      (wstrb),
    .wlast_i      (wlast),
    .bready_i     (bready),
    .resp_valid_i (resp_valid),
    .resp_i       (resp),
    .err_cnt_o    (err_cnt),
    .resp_cnt_o   (resp_cnt),
    .bp_cnt_o     (bp_cnt)
  );

  // One command, then its bytes; handshakes are judged at the falling edge
  task automatic send_command(input int k, input bit gaps);
    int j;
    bit hs;
    cmd_valid <= 1'b1;
    cmd       <= cmds[k];
    hs = 1'b0;
    while (!hs) begin
      @(negedge aclk);
      hs = cmd_ready;
      @(posedge aclk);
    end
    cmd_valid <= 1'b0;
    for (j = 0; j < nbytes[k]; j++) begin
      if (gaps && ($random(seed) & 1)) begin
        dat_tvalid <= 1'b0;  // Idle cycle between bytes
        @(posedge aclk);
      end
      dat_tvalid <= 1'b1;
      dat_tdata  <= 8'($random(seed));
      dat_tlast  <= (j == nbytes[k] - 1);
      hs = 1'b0;
      while (!hs) begin
        @(negedge aclk);
        hs = dat_tready;
        @(posedge aclk);
      end
    end
    dat_tvalid <= 1'b0;
    dat_tlast  <= 1'b0;
  endtask

  // AXI slave, sampled at the falling edge and driven at the rising edge
  always @(negedge aclk) begin
    aw_take  = awvalid && awready;
    wl_take  = wvalid && wready && wlast;
    b_take   = bvalid && bready;
    aw_id_s  = awid;
    aw_err_s = awaddr[2];  // Bit 2 selects an error response
  end

  always @(posedge aclk) begin
    if (!aresetn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= stall ? (($random(rsp_seed) & 7) == 0) : 1'b1;
      wready  <= stall ? (($random(rsp_seed) & 7) == 0) : 1'b1;
      if (aw_take) begin
        pend_id  <= aw_id_s;
        pend_err <= aw_err_s;
      end
      if (b_take) begin
        bvalid <= 1'b0;
      end else if (wl_take) begin
        bvalid <= 1'b1;  // Answer after the last beat
        bid    <= pend_id;
        bresp  <= pend_err ? bridge_pkg::RESP_SLVERR : bridge_pkg::RESP_OKAY;
      end
    end
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles with %0d of %0d bursts answered",
               cycles, resp_cnt, NCMD);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    total    = 0;
    rsp_seed = seed + 1;  // Responder has its own stream
    for (i = 0; i < NCMD; i++) begin
      if (i < 6) begin
        n = 4 * (1 + ($random(seed) & 7));
      end else if (i < 12) begin
        n = 4 * ($random(seed) & 7);
        n = n + 1 + (($random(seed) & 255) % 3);  // Remainder 1 to 3
      end else begin
        n = 1 + ($random(seed) & 63);
      end
      nbytes[i]    = n;
      cmds[i].id   = 4'($random(seed));
      cmds[i].addr = $random(seed) & 32'hFFFF_FFFC;
      cmds[i].len  = 8'((n + 3) / 4 - 1);
      total        = total + n;
    end
    limit = total * 8 + 200;
    repeat (3) @(posedge aclk);
    aresetn <= 1'b1;
    repeat (3) @(posedge aclk);
    for (i = 0; i < NCMD; i++) begin
      stall <= (i >= 12);
      send_command(i, i < 12);
    end
    while (resp_cnt < NCMD) @(negedge aclk);
    repeat (4) @(negedge aclk);
    if (bp_cnt == 0) begin
      $display("back-pressure: dat_tready_o never fell while a byte waited");
    end
    $display("tests %0d, bursts answered %0d of %0d, errors %0d",
             resp_cnt + 1, resp_cnt, NCMD, err_cnt);
    if (err_cnt == 0 && resp_cnt == NCMD && bp_cnt != 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_axi_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_checker (
  input  wire                       aclk,
  input  wire                       aresetn,
  input  wire                       cmd_valid_i,
  input  wire                       cmd_ready_i,
  input  wire bridge_pkg::wr_cmd_t  cmd_i,
  input  wire                       dat_tvalid_i,
  input  wire                       dat_tready_i,
  input  wire [7:0]                 dat_tdata_i,
  input  wire                       dat_tlast_i,
  input  wire                       awvalid_i,
  input  wire                       awready_i,
  input  wire [31:0]                awaddr_i,
  input  wire [7:0]                 awlen_i,
  input  wire [3:0]                 awid_i,
  input  wire                       wvalid_i,
  input  wire                       wready_i,
  input  wire [31:0]                wdata_i,
  input  wire [3:0]                 wstrb_i,
  input  wire                       wlast_i,
  input  wire                       bready_i,
  input  wire                       resp_valid_i,
  input  wire bridge_pkg::wr_resp_t resp_i,
  output int                        err_cnt_o,
  output int                        resp_cnt_o,
  output int                        bp_cnt_o
);

  bridge_pkg::wr_cmd_t  aw_exp [$];  // Expected AW, in command order
  bridge_pkg::wr_word_t w_exp [$];
  bridge_pkg::wr_resp_t r_exp [$];
  bridge_pkg::wr_word_t cur = '0;    // Word being assembled from the byte stream
  bridge_pkg::wr_cmd_t  ce;
  bridge_pkg::wr_word_t we;
  bridge_pkg::wr_resp_t re;
  logic [31:0]          mask;
  int                   lane = 0;
  int                   post_rst = 0;
  int                   errors = 0;
  int                   resps = 0;
  int                   bp_stalls = 0;  // Cycles with a byte held off by dat_tready
  int                   err_mark = 0;
  string                tname = "reset";

  assign err_cnt_o  = errors;
  assign resp_cnt_o = resps;
  assign bp_cnt_o   = bp_stalls;

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s %s: expected %h, actual %h", tname, what, exp, act);
      errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("%s: %s", tname, msg);
    errors++;
  endtask

  // Everything is stable at the falling edge
  always @(negedge aclk) begin
    if (!aresetn) begin
      post_rst = 0;
      if (cmd_ready_i !== 1'b0) begin
        report_error("cmd_ready_o is high during reset");
      end
    end else begin
      if (post_rst == 0) begin
        check_value("awvalid", 32'd0, 32'(awvalid_i));
        check_value("wvalid", 32'd0, 32'(wvalid_i));
        check_value("bready", 32'd0, 32'(bready_i));
        check_value("resp_valid", 32'd0, 32'(resp_valid_i));
      end
      if (post_rst == 1) begin
        check_value("cmd_ready", 32'd1, 32'(cmd_ready_i));
        $display("reset: %s", (errors == 0) ? "passed" : "failed");
        err_mark = errors;
        tname    = $sformatf("burst_%0d", resps);
      end
      if (post_rst < 2) begin
        post_rst++;
      end

      if (dat_tvalid_i && !dat_tready_i) begin
        bp_stalls++;
      end

      if (cmd_valid_i && cmd_ready_i) begin
        aw_exp.push_back(cmd_i);
        re.id   = cmd_i.id;
        re.okay = !cmd_i.addr[2];  // Responder rule
        r_exp.push_back(re);
      end
      if (dat_tvalid_i && dat_tready_i) begin
        cur.data[8*lane +: 8] = dat_tdata_i;  // Low byte first
        cur.strb[lane]        = 1'b1;
        if (dat_tlast_i || lane == 3) begin
          cur.last = dat_tlast_i;
          w_exp.push_back(cur);
          cur  = '0;
          lane = 0;
        end else begin
          lane++;
        end
      end

      if (awvalid_i && awready_i) begin
        if (aw_exp.size() == 0) begin
          report_error("AW handshake with no command pending");
        end else begin
          ce = aw_exp.pop_front();
          check_value("awaddr", ce.addr, awaddr_i);
          check_value("awlen", 32'(ce.len), 32'(awlen_i));
          check_value("awid", 32'(ce.id), 32'(awid_i));
        end
      end
      if (wvalid_i && wready_i) begin
        if (w_exp.size() == 0) begin
          report_error("W beat with no data word pending");
        end else begin
          we   = w_exp.pop_front();
          mask = {{8{we.strb[3]}}, {8{we.strb[2]}}, {8{we.strb[1]}}, {8{we.strb[0]}}};
          check_value("wdata", we.data & mask, wdata_i & mask);  // Bytes under strobe
          check_value("wstrb", 32'(we.strb), 32'(wstrb_i));
          check_value("wlast", 32'(we.last), 32'(wlast_i));
        end
      end
      if (resp_valid_i) begin
        if (r_exp.size() == 0) begin
          report_error("status pulse with no command pending");
        end else begin
          re = r_exp.pop_front();
          check_value("resp id", 32'(re.id), 32'(resp_i.id));
          check_value("resp okay", 32'(re.okay), 32'(resp_i.okay));
          $display("%s id %0d: %s", tname, re.id, (errors == err_mark) ? "passed" : "failed");
        end
        resps++;
        err_mark = errors;
        tname    = $sformatf("burst_%0d", resps);
      end
    end
  end

endmodule

`default_nettype wire

// File: cmd_to_axi_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_to_axi_assert (
  input wire                       aclk,
  input wire                       aresetn,
  input wire                       awvalid_i,
  input wire                       awready_i,
  input wire                       wvalid_i,
  input wire                       wready_i,
  input wire                       wlast_i,
  input wire bridge_pkg::wr_word_t word_i,
  input wire                       bvalid_i,
  input wire                       bready_i,
  input wire                       resp_valid_i
);

  // Valids hold until accepted
  aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    awvalid_i && !awready_i |=> awvalid_i)
    else $error("awvalid dropped before awready");

  w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    wvalid_i && !wready_i |=> wvalid_i)
    else $error("wvalid dropped before wready");

  // Beat count and packer agree on the last word
  wlast_match: assert property (@(posedge aclk) disable iff (!aresetn)
    wvalid_i |-> (wlast_i == word_i.last))
    else $error("wlast differs from the last flag of the word");

  resp_after_b: assert property (@(posedge aclk) disable iff (!aresetn)
    resp_valid_i |-> $past(bvalid_i && bready_i))
    else $error("status pulse without a B handshake");

endmodule

bind axi_write_master cmd_to_axi_assert u_assert (
  .aclk         (aclk),
  .aresetn      (aresetn),
  .awvalid_i    (awvalid_o),
  .awready_i    (awready_i),
  .wvalid_i     (wvalid_o),
  .wready_i     (wready_i),
  .wlast_i      (wlast_o),
  .word_i       (word_i),
  .bvalid_i     (bvalid_i),
  .bready_i     (bready_o),
  .resp_valid_i (resp_valid_o)
);

`default_nettype wire

// File: cmd_to_axi_top.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_to_axi_top #(
  parameter int CMD_DEPTH  = 4,
  parameter int DATA_DEPTH = 16
) (
  input  wire                      aclk,
  input  wire                      aresetn,

  // Decoded commands
  input  wire                      cmd_valid_i,
  output logic                     cmd_ready_o,
  input  wire bridge_pkg::wr_cmd_t cmd_i,

  // Byte stream
  input  wire                      dat_tvalid_i,
  output logic                     dat_tready_o,
  input  wire [7:0]                dat_tdata_i,
  input  wire                      dat_tlast_i,

  // AXI4 write channels, INCR bursts only
  output logic                     awvalid_o,
  input  wire                      awready_i,
  output logic [31:0]              awaddr_o,
  output logic [7:0]               awlen_o,
  output logic [3:0]               awid_o,

  output logic                     wvalid_o,
  input  wire                      wready_i,
  output logic [31:0]              wdata_o,
  output logic [3:0]               wstrb_o,
  output logic                     wlast_o,

  input  wire                      bvalid_i,
  output logic                     bready_o,
  input  wire [1:0]                bresp_i,
  input  wire [3:0]                bid_i,

  // Write status
  output logic                     resp_valid_o,
  output bridge_pkg::wr_resp_t     resp_o
);

  bridge_pkg::wr_cmd_t  pk_cmd;     // Packer to command buffer
  bridge_pkg::wr_cmd_t  fifo_cmd;   // Command buffer to master
  bridge_pkg::wr_word_t pk_word;
  bridge_pkg::wr_word_t fifo_word;
  logic                 cmd_push;
  logic                 cmd_credit;
  logic                 cmd_valid;
  logic                 cmd_pop;
  logic                 word_push;
  logic                 word_credit;
  logic                 word_valid;
  logic                 word_pop;

  cmd_packer #(
    .CMD_DEPTH  (CMD_DEPTH),
    .DATA_DEPTH (DATA_DEPTH)
  ) u_packer (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .cmd_i         (cmd_i),
    .dat_tvalid_i  (dat_tvalid_i),
    .dat_tready_o  (dat_tready_o),
    .dat_tdata_i   (dat_tdata_i),
    .dat_tlast_i   (dat_tlast_i),
    .cmd_push_o    (cmd_push),
    .cmd_o         (pk_cmd),
    .cmd_credit_i  (cmd_credit),
    .word_push_o   (word_push),
    .word_o        (pk_word),
    .word_credit_i (word_credit)
  );

  credit_fifo #(
    .DEPTH     (CMD_DEPTH),
    .payload_t (bridge_pkg::wr_cmd_t)
  ) u_cmd_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push_i    (cmd_push),
    .payload_i (pk_cmd),
    .valid_o   (cmd_valid),
    .payload_o (fifo_cmd),
    .pop_i     (cmd_pop),
    .credit_o  (cmd_credit)
  );

  credit_fifo #(
    .DEPTH     (DATA_DEPTH),
    .payload_t (bridge_pkg::wr_word_t)
  ) u_word_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push_i    (word_push),
    .payload_i (pk_word),
    .valid_o   (word_valid),
    .payload_o (fifo_word),
    .pop_i     (word_pop),
    .credit_o  (word_credit)
  );

  axi_write_master u_master (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .cmd_valid_i  (cmd_valid),
    .cmd_i        (fifo_cmd),
    .cmd_pop_o    (cmd_pop),
    .word_valid_i (word_valid),
    .word_i       (fifo_word),
    .word_pop_o   (word_pop),
    .awvalid_o    (awvalid_o),
    .awready_i    (awready_i),
    .awaddr_o     (awaddr_o),
    .awlen_o      (awlen_o),
    .awid_o       (awid_o),
    .wvalid_o     (wvalid_o),
    .wready_i     (wready_i),
    .wdata_o      (wdata_o),
    .wstrb_o      (wstrb_o),
    .wlast_o      (wlast_o),
    .bvalid_i     (bvalid_i),
    .bready_o     (bready_o),
    .bresp_i      (bresp_i),
    .bid_i        (bid_i),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

endmodule

`default_nettype wire

// File: axi_write_master.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_master (
  input  wire                       aclk,
  input  wire                       aresetn,

  // Command buffer
  input  wire                       cmd_valid_i,
  input  wire bridge_pkg::wr_cmd_t  cmd_i,
  output logic                      cmd_pop_o,

  // Word buffer
  input  wire                       word_valid_i,
  input  wire bridge_pkg::wr_word_t word_i,
  output logic                      word_pop_o,

  // AXI write address
  output logic                      awvalid_o,
  input  wire                       awready_i,
  output logic [31:0]               awaddr_o,
  output logic [7:0]                awlen_o,
  output logic [3:0]                awid_o,

  // AXI write data
  output logic                      wvalid_o,
  input  wire                       wready_i,
  output logic [31:0]               wdata_o,
  output logic [3:0]                wstrb_o,
  output logic                      wlast_o,

  // AXI write response
  input  wire                       bvalid_i,
  output logic                      bready_o,
  input  wire [1:0]                 bresp_i,
  input  wire [3:0]                 bid_i,

  // Status
  output logic                      resp_valid_o,
  output bridge_pkg::wr_resp_t      resp_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_RESP
  } state_t;

  state_t              state_q;
  bridge_pkg::wr_cmd_t cmd_q;   // Burst in progress
  logic [7:0]          beat_q;  // W beats sent so far
  logic                aw_hs;
  logic                w_hs;
  logic                b_hs;

  assign cmd_pop_o = (state_q == ST_IDLE) && cmd_valid_i;

  assign awvalid_o = (state_q == ST_ADDR);
  assign awaddr_o  = cmd_q.addr;
  assign awlen_o   = cmd_q.len;
  assign awid_o    = cmd_q.id;

  // The word buffer output is registered, so wvalid holds until wready
  assign wvalid_o   = (state_q == ST_DATA) && word_valid_i;
  assign wdata_o    = word_i.data;
  assign wstrb_o    = word_i.strb;
  assign wlast_o    = (beat_q == cmd_q.len);
  assign word_pop_o = w_hs;

  assign bready_o = (state_q == ST_RESP);

  assign aw_hs = awvalid_o && awready_i;
  assign w_hs  = wvalid_o && wready_i;
  assign b_hs  = bvalid_i && bready_o;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state_q      <= ST_IDLE;
      beat_q       <= 8'd0;
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= b_hs;  // One pulse per B response
      case (state_q)
        ST_IDLE: begin
          if (cmd_pop_o) begin
            state_q <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (aw_hs) begin
            state_q <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (w_hs && wlast_o) begin
            beat_q  <= 8'd0;
            state_q <= ST_RESP;
          end else if (w_hs) begin
            beat_q <= beat_q + 8'd1;
          end
        end
        ST_RESP: begin
          if (b_hs) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (cmd_pop_o) begin
      cmd_q <= cmd_i;
    end
    if (b_hs) begin
      resp_o.id   <= bid_i;
      resp_o.okay <= (bresp_i == bridge_pkg::RESP_OKAY);
    end
  end

endmodule

`default_nettype wire

// File: credit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
  parameter int  DEPTH     = 4,
  parameter type payload_t = logic [7:0]
) (
  input  wire           aclk,
  input  wire           aresetn,

  input  wire           push_i,
  input  wire payload_t payload_i,

  output logic          valid_o,
  output payload_t      payload_o,
  input  wire           pop_i,

  output logic          credit_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int LW = $clog2(DEPTH + 1);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [LW-1:0] level_q;  // Entries in mem, output register not counted
  logic          pop;
  logic          load;
  logic          mem_rd;
  logic          mem_wr;

  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    ptr_inc = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign pop    = valid_o && pop_i;
  assign load   = !valid_o || pop;                     // Output register free next cycle
  assign mem_rd = load && (level_q != '0);
  assign mem_wr = push_i && !(load && (level_q == '0));  // Else straight to the output

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
      valid_o  <= 1'b0;
      credit_o <= 1'b0;
    end else begin
      credit_o <= pop;
      if (load) begin
        valid_o <= mem_rd || push_i;
      end
      if (mem_wr) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (mem_rd) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      level_q <= level_q + LW'(mem_wr) - LW'(mem_rd);
    end
  end

  always_ff @(posedge aclk) begin
    if (mem_wr) begin
      mem[wr_ptr_q] <= payload_i;
    end
    if (mem_rd) begin
      payload_o <= mem[rd_ptr_q];
    end else if (load && push_i) begin
      payload_o <= payload_i;  // Empty buffer, bypass
    end
  end

endmodule

`default_nettype wire

// File: cmd_packer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_packer #(
  parameter int CMD_DEPTH  = 4,
  parameter int DATA_DEPTH = 16
) (
  input  wire                      aclk,
  input  wire                      aresetn,

  input  wire                      cmd_valid_i,
  output logic                     cmd_ready_o,
  input  wire bridge_pkg::wr_cmd_t cmd_i,

  input  wire                      dat_tvalid_i,
  output logic                     dat_tready_o,
  input  wire [7:0]                dat_tdata_i,
  input  wire                      dat_tlast_i,

  output logic                     cmd_push_o,
  output bridge_pkg::wr_cmd_t      cmd_o,
  input  wire                      cmd_credit_i,

  output logic                     word_push_o,
  output bridge_pkg::wr_word_t     word_o,
  input  wire                      word_credit_i
);

  localparam int CCW = $clog2(CMD_DEPTH + 1);
  localparam int WCW = $clog2(DATA_DEPTH + 1);

  logic           busy_q;      // Bytes of the current command still to come
  logic           cmd_rdy_q;
  logic [CCW-1:0] cmd_cnt_q;   // Free entries in the command buffer
  logic [WCW-1:0] word_cnt_q;  // Free entries in the word buffer
  logic [1:0]     idx_q;       // Lane of the next byte
  logic [3:0]     strb_q;
  logic [31:0]    data_q;

  logic           cmd_acc;
  logic           byte_acc;
  logic           word_close;
  logic           busy_d;
  logic [CCW-1:0] cmd_cnt_d;
  logic [WCW-1:0] word_cnt_d;
  logic [31:0]    data_nx;
  logic [3:0]     strb_nx;

  assign cmd_ready_o  = cmd_rdy_q;
  assign dat_tready_o = busy_q && (word_cnt_q != '0);  // Stall bytes without a word credit

  assign cmd_acc    = cmd_valid_i && cmd_rdy_q;
  assign byte_acc   = dat_tvalid_i && dat_tready_o;
  assign word_close = byte_acc && (dat_tlast_i || (idx_q == 2'd3));

  // Current byte placed in its lane, low byte first
  always_comb begin
    data_nx = data_q;
    data_nx[8*idx_q +: 8] = dat_tdata_i;
  end

  assign strb_nx = strb_q | (4'b0001 << idx_q);

  // A credit is taken when an entry is committed and comes back on each pop
  assign cmd_cnt_d  = cmd_cnt_q - CCW'(cmd_acc) + CCW'(cmd_credit_i);
  assign word_cnt_d = word_cnt_q - WCW'(word_close) + WCW'(word_credit_i);
  assign busy_d     = cmd_acc || (busy_q && !(byte_acc && dat_tlast_i));

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      busy_q      <= 1'b0;
      cmd_rdy_q   <= 1'b0;
      cmd_cnt_q   <= CCW'(CMD_DEPTH);
      word_cnt_q  <= WCW'(DATA_DEPTH);
      idx_q       <= 2'd0;
      strb_q      <= 4'd0;
      cmd_push_o  <= 1'b0;
      word_push_o <= 1'b0;
    end else begin
      busy_q      <= busy_d;
      cmd_rdy_q   <= !busy_d && (cmd_cnt_d != '0);  // Idle with room for a command
      cmd_cnt_q   <= cmd_cnt_d;
      word_cnt_q  <= word_cnt_d;
      cmd_push_o  <= cmd_acc;
      word_push_o <= word_close;
      if (word_close) begin
        idx_q  <= 2'd0;
        strb_q <= 4'd0;
      end else if (byte_acc) begin
        idx_q  <= idx_q + 2'd1;
        strb_q <= strb_nx;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (cmd_acc) begin
      cmd_o <= cmd_i;
    end
    if (byte_acc) begin
      data_q <= data_nx;
    end
    if (word_close) begin
      word_o.data <= data_nx;
      word_o.strb <= strb_nx;
      word_o.last <= dat_tlast_i;
    end
  end

endmodule

`default_nettype wire

// File: bridge_pkg.sv
`default_nettype none

package bridge_pkg;

  // Decoded write command, one per AXI burst
  typedef struct packed {
    logic [3:0]  id;    // AXI transaction id
    logic [7:0]  len;   // Beats minus one, as awlen
    logic [31:0] addr;  // Burst start address
  } wr_cmd_t;

  // Packed data word, one per W beat
  typedef struct packed {
    logic [31:0] data;  // Byte 0 in bits 7:0
    logic [3:0]  strb;  // One bit per byte held
    logic        last;  // Word that took the tlast byte
  } wr_word_t;

  // Status returned per B response
  typedef struct packed {
    logic [3:0] id;
    logic       okay;   // bresp was OKAY
  } wr_resp_t;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
